// ==== hdl/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Shared bus geometry
// Byte address width seen by both caches
`define BUS_ADDRESS_WIDTH 20
// Log2 of bytes per line
`define BUS_DATA_WIDTH_SHIFT 4
// One line in bits, 128 here
`define BUS_DATA_WIDTH ((1 << `BUS_DATA_WIDTH_SHIFT) * 8)
// Line address, byte address minus offset
`define LINE_ADDR_WIDTH (`BUS_ADDRESS_WIDTH - `BUS_DATA_WIDTH_SHIFT)

// Core word
`define WORD_WIDTH 32
// Word select inside a line
`define WORD_SEL_BITS (`BUS_DATA_WIDTH_SHIFT - 2)

// Cache sizes, log2 of line count
`define ICACHE_INDEX_BITS 4
`define DCACHE_INDEX_BITS 4

`endif

// ==== hdl/mem_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Scalar types
   ////////////////////////////////////////////////////////////////////////////

   // Full byte address from the core
   typedef logic [`BUS_ADDRESS_WIDTH-1:0] byte_addr_t;

   // Line address on the bus
   typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

   // One cache line
   typedef logic [`BUS_DATA_WIDTH-1:0] line_t;

   // Core word
   typedef logic [`WORD_WIDTH-1:0] word_t;

   ////////////////////////////////////////////////////////////////////////////
   // Request bundles
   ////////////////////////////////////////////////////////////////////////////

   // Cache to bus request
   // valid held until the memory answers
   typedef struct packed {
      line_addr_t addr;
      logic       we;
      logic       valid;
   } bus_req_t;

   // Core to data cache access
   // Whole word stores only
   typedef struct packed {
      byte_addr_t addr;
      logic       we;
      word_t      wdata;
      logic       valid;
   } data_req_t;

endpackage

`default_nettype wire

// ==== hdl/cache_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter (
   input  wire                     clk_i,
   input  wire                     rst_i,
   // Ownership hints from the caches
   input  wire                     icache_blocking_n_i,
   input  wire                     dcache_flushing_n_i,
   // Requests from both caches
   input  wire mem_pkg::bus_req_t  icache_req_i,
   input  wire mem_pkg::bus_req_t  dcache_req_i,
   // Memory response
   input  wire                     bus_valid_i,
   output logic                    icache_bus_valid_o,
   output logic                    dcache_bus_valid_o,
   // Request toward memory
   output mem_pkg::bus_req_t       bus_req_o
);

   import mem_pkg::*;

   // Request of the current owner
   bus_req_t sel_req;

   // Owner, 0 is icache and 1 is dcache
   logic cache_sel_q;
   // Owner wanted right now
   logic cache_sel_next;
   // Switch pending
   logic updating_q;

   // Dcache only when icache is not refilling and dcache asks
   assign cache_sel_next = icache_blocking_n_i & ~dcache_flushing_n_i;

   ////////////////////////////////////////////////////////////////////////////
   // Bus mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      sel_req = cache_sel_q ? dcache_req_i : icache_req_i;
      bus_req_o = sel_req;
      // Icache never writes
      bus_req_o.we = cache_sel_q & sel_req.we;
   end

   // Response to the owner only, dropped while switching
   assign icache_bus_valid_o = ~cache_sel_q & bus_valid_i & ~updating_q;
   assign dcache_bus_valid_o = cache_sel_q & bus_valid_i & ~updating_q;

   ////////////////////////////////////////////////////////////////////////////
   // Owner switch, falling edge
   ////////////////////////////////////////////////////////////////////////////

   // Mid-cycle update keeps the memory from sampling a half-switched request
   always_ff @(negedge clk_i) begin
      if (rst_i) begin
         cache_sel_q <= 1'b0;
         updating_q <= 1'b0;
      end else if (updating_q) begin
         // Finish once memory has let go of valid
         if (!bus_valid_i) begin
            cache_sel_q <= cache_sel_next;
            updating_q <= 1'b0;
         end
      end else if (!sel_req.valid && (cache_sel_q != cache_sel_next)) begin
         // Owner idle and another owner wanted
         updating_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module icache (
   input  wire                      clk_i,
   input  wire                      rst_i,
   // Core fetch side
   input  wire mem_pkg::byte_addr_t fetch_addr_i,
   input  wire                      fetch_req_i,
   input  wire                      invalidate_i,
   output mem_pkg::word_t           fetch_data_o,
   output logic                     fetch_valid_o,
   output logic                     blocking_n_o,
   // Shared bus side
   output mem_pkg::bus_req_t        bus_req_o,
   input  wire                      bus_valid_i,
   input  wire mem_pkg::line_t      bus_rdata_i
);

   import mem_pkg::*;

   localparam int unsigned NUM_LINES = 1 << `ICACHE_INDEX_BITS;
   localparam int unsigned TAG_BITS = `LINE_ADDR_WIDTH - `ICACHE_INDEX_BITS;

   // Tag and data arrays
   logic [TAG_BITS-1:0]  tag_q [NUM_LINES];
   line_t                line_q [NUM_LINES];
   logic [NUM_LINES-1:0] valid_q;

   // Refill in progress
   logic       refill_q;
   // Bus request valid
   logic       req_valid_q;
   // Fetch address that missed
   byte_addr_t miss_addr_q;

   // Incoming fetch fields
   logic [`ICACHE_INDEX_BITS-1:0] fetch_idx;
   logic [TAG_BITS-1:0]           fetch_tag;
   logic [`WORD_SEL_BITS-1:0]     fetch_off;
   logic                          fetch_hit;

   // Latched miss fields
   logic [`ICACHE_INDEX_BITS-1:0] miss_idx;
   logic [TAG_BITS-1:0]           miss_tag;
   logic [`WORD_SEL_BITS-1:0]     miss_off;
   logic                          refill_done;

   ////////////////////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////////////////////

   assign fetch_off = fetch_addr_i[2 +: `WORD_SEL_BITS];
   assign fetch_idx = fetch_addr_i[`BUS_DATA_WIDTH_SHIFT +: `ICACHE_INDEX_BITS];
   assign fetch_tag = fetch_addr_i[`BUS_ADDRESS_WIDTH-1 -: TAG_BITS];
   assign fetch_hit = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);

   assign miss_off = miss_addr_q[2 +: `WORD_SEL_BITS];
   assign miss_idx = miss_addr_q[`BUS_DATA_WIDTH_SHIFT +: `ICACHE_INDEX_BITS];
   assign miss_tag = miss_addr_q[`BUS_ADDRESS_WIDTH-1 -: TAG_BITS];

   // Line arrives for our miss
   assign refill_done = refill_q & bus_valid_i;

   // Read only, we tied low
   assign bus_req_o = '{
      addr:  miss_addr_q[`BUS_ADDRESS_WIDTH-1:`BUS_DATA_WIDTH_SHIFT],
      we:    1'b0,
      valid: req_valid_q
   };

   // Arbiter keeps the bus on our side while low
   assign blocking_n_o = ~refill_q;

   // Control path
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         refill_q <= 1'b0;
         req_valid_q <= 1'b0;
         valid_q <= '0;
         fetch_valid_o <= 1'b0;
      end else begin
         fetch_valid_o <= 1'b0;
         // Whole cache invalidate, a refill below still wins
         if (invalidate_i) begin
            valid_q <= '0;
         end
         if (refill_q) begin
            if (bus_valid_i) begin
               refill_q <= 1'b0;
               req_valid_q <= 1'b0;
               valid_q[miss_idx] <= 1'b1;
               fetch_valid_o <= 1'b1;
            end else begin
               // Raised one cycle after entry
               req_valid_q <= 1'b1;
            end
         end else if (fetch_req_i) begin
            if (fetch_hit) begin
               fetch_valid_o <= 1'b1;
            end else begin
               refill_q <= 1'b1;
            end
         end
      end
   end

   // Arrays and returned word
   always_ff @(posedge clk_i) begin
      if (!refill_q && fetch_req_i) begin
         miss_addr_q <= fetch_addr_i;
         fetch_data_o <= line_q[fetch_idx][fetch_off * `WORD_WIDTH +: `WORD_WIDTH];
      end
      if (refill_done) begin
         line_q[miss_idx] <= bus_rdata_i;
         tag_q[miss_idx] <= miss_tag;
         // Critical word straight from the bus
         fetch_data_o <= bus_rdata_i[miss_off * `WORD_WIDTH +: `WORD_WIDTH];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module dcache (
   input  wire                     clk_i,
   input  wire                     rst_i,
   // Core side
   input  wire mem_pkg::data_req_t req_i,
   input  wire                     flush_i,
   output mem_pkg::word_t          rdata_o,
   output logic                    resp_valid_o,
   output logic                    flush_done_o,
   // Bus ownership hint
   output logic                    flushing_n_o,
   // Shared bus side
   output mem_pkg::bus_req_t       bus_req_o,
   output mem_pkg::line_t          bus_wdata_o,
   input  wire                     bus_valid_i,
   input  wire mem_pkg::line_t     bus_rdata_i
);

   import mem_pkg::*;

   localparam int unsigned NUM_LINES = 1 << `DCACHE_INDEX_BITS;
   localparam int unsigned TAG_BITS = `LINE_ADDR_WIDTH - `DCACHE_INDEX_BITS;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WRITEBACK,
      S_REFILL,
      S_FLUSH,
      S_FLUSH_WB
   } state_t;

   state_t state_q;

   // Arrays
   logic [TAG_BITS-1:0]  tag_q [NUM_LINES];
   line_t                line_q [NUM_LINES];
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // Access that missed
   data_req_t req_q;
   // Bus request register
   bus_req_t  bus_req_q;
   // Flush walk position
   logic [`DCACHE_INDEX_BITS-1:0] flush_idx_q;

   // Incoming access fields
   logic [`DCACHE_INDEX_BITS-1:0] req_idx;
   logic [TAG_BITS-1:0]           req_tag;
   logic [`WORD_SEL_BITS-1:0]     req_off;
   logic                          req_hit;
   logic                          idle_access;

   // Miss fields
   logic [`DCACHE_INDEX_BITS-1:0] miss_idx;
   logic [TAG_BITS-1:0]           miss_tag;
   logic [`WORD_SEL_BITS-1:0]     miss_off;
   logic                          refill_done;
   line_t                         refill_line;

   assign req_off = req_i.addr[2 +: `WORD_SEL_BITS];
   assign req_idx = req_i.addr[`BUS_DATA_WIDTH_SHIFT +: `DCACHE_INDEX_BITS];
   assign req_tag = req_i.addr[`BUS_ADDRESS_WIDTH-1 -: TAG_BITS];
   assign req_hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
   assign idle_access = (state_q == S_IDLE) && req_i.valid;

   assign miss_off = req_q.addr[2 +: `WORD_SEL_BITS];
   assign miss_idx = req_q.addr[`BUS_DATA_WIDTH_SHIFT +: `DCACHE_INDEX_BITS];
   assign miss_tag = req_q.addr[`BUS_ADDRESS_WIDTH-1 -: TAG_BITS];
   assign refill_done = (state_q == S_REFILL) && bus_valid_i;

   // Store miss merges its word into the fetched line
   always_comb begin
      refill_line = bus_rdata_i;
      if (req_q.we) begin
         refill_line[miss_off * `WORD_WIDTH +: `WORD_WIDTH] = req_q.wdata;
      end
   end

   assign bus_req_o = bus_req_q;
   // Line at the bus index, untouched until the refill lands
   assign bus_wdata_o = line_q[bus_req_q.addr[`DCACHE_INDEX_BITS-1:0]];
   // Any non-idle state needs the bus
   assign flushing_n_o = (state_q == S_IDLE);

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         valid_q <= '0;
         dirty_q <= '0;
         bus_req_q <= '0;
         flush_idx_q <= '0;
         resp_valid_o <= 1'b0;
         flush_done_o <= 1'b0;
      end else begin
         resp_valid_o <= 1'b0;
         flush_done_o <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (req_i.valid) begin
                  if (req_hit) begin
                     resp_valid_o <= 1'b1;
                     if (req_i.we) begin
                        dirty_q[req_idx] <= 1'b1;
                     end
                  end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
                     // Victim goes out first
                     bus_req_q.addr <= {tag_q[req_idx], req_idx};
                     bus_req_q.we <= 1'b1;
                     state_q <= S_WRITEBACK;
                  end else begin
                     bus_req_q.addr <= req_i.addr[`BUS_ADDRESS_WIDTH-1:`BUS_DATA_WIDTH_SHIFT];
                     bus_req_q.we <= 1'b0;
                     state_q <= S_REFILL;
                  end
               end else if (flush_i) begin
                  flush_idx_q <= '0;
                  state_q <= S_FLUSH;
               end
            end
            S_WRITEBACK: begin
               if (bus_valid_i) begin
                  // Valid stays low one cycle before the refill
                  bus_req_q.valid <= 1'b0;
                  bus_req_q.addr <= req_q.addr[`BUS_ADDRESS_WIDTH-1:`BUS_DATA_WIDTH_SHIFT];
                  bus_req_q.we <= 1'b0;
                  state_q <= S_REFILL;
               end else begin
                  bus_req_q.valid <= 1'b1;
               end
            end
            S_REFILL: begin
               if (bus_valid_i) begin
                  bus_req_q.valid <= 1'b0;
                  valid_q[miss_idx] <= 1'b1;
                  dirty_q[miss_idx] <= req_q.we;
                  resp_valid_o <= 1'b1;
                  state_q <= S_IDLE;
               end else begin
                  bus_req_q.valid <= 1'b1;
               end
            end
            S_FLUSH: begin
               if (valid_q[flush_idx_q] && dirty_q[flush_idx_q]) begin
                  bus_req_q.addr <= {tag_q[flush_idx_q], flush_idx_q};
                  bus_req_q.we <= 1'b1;
                  state_q <= S_FLUSH_WB;
               end else if (flush_idx_q == '1) begin
                  flush_done_o <= 1'b1;
                  state_q <= S_IDLE;
               end else begin
                  flush_idx_q <= flush_idx_q + 1'b1;
               end
            end
            S_FLUSH_WB: begin
               if (bus_valid_i) begin
                  // Line stays valid, now clean
                  bus_req_q.valid <= 1'b0;
                  dirty_q[flush_idx_q] <= 1'b0;
                  state_q <= S_FLUSH;
               end else begin
                  bus_req_q.valid <= 1'b1;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Arrays, latched access, load data
   always_ff @(posedge clk_i) begin
      if (idle_access) begin
         req_q <= req_i;
         rdata_o <= line_q[req_idx][req_off * `WORD_WIDTH +: `WORD_WIDTH];
         if (req_hit && req_i.we) begin
            line_q[req_idx][req_off * `WORD_WIDTH +: `WORD_WIDTH] <= req_i.wdata;
         end
      end
      if (refill_done) begin
         line_q[miss_idx] <= refill_line;
         tag_q[miss_idx] <= miss_tag;
         rdata_o <= bus_rdata_i[miss_off * `WORD_WIDTH +: `WORD_WIDTH];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem (
   input  wire                      clk_i,
   input  wire                      rst_i,
   // Instruction fetch port
   input  wire mem_pkg::byte_addr_t fetch_addr_i,
   input  wire                      fetch_req_i,
   input  wire                      fetch_invalidate_i,
   output mem_pkg::word_t           fetch_data_o,
   output logic                     fetch_valid_o,
   // Data port
   input  wire mem_pkg::data_req_t  data_req_i,
   input  wire                      data_flush_i,
   output mem_pkg::word_t           data_rdata_o,
   output logic                     data_resp_valid_o,
   output logic                     data_flush_done_o,
   // Shared line bus
   output mem_pkg::bus_req_t        bus_req_o,
   output mem_pkg::line_t           bus_wdata_o,
   input  wire                      bus_valid_i,
   input  wire mem_pkg::line_t      bus_rdata_i
);

   import mem_pkg::*;

   // Per-cache bus requests
   bus_req_t icache_bus_req;
   bus_req_t dcache_bus_req;

   // Gated responses
   logic icache_bus_valid;
   logic dcache_bus_valid;

   // Ownership hints
   logic icache_blocking_n;
   logic dcache_flushing_n;

   icache u_icache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fetch_addr_i (fetch_addr_i),
      .fetch_req_i  (fetch_req_i),
      .invalidate_i (fetch_invalidate_i),
      .fetch_data_o (fetch_data_o),
      .fetch_valid_o(fetch_valid_o),
      .blocking_n_o (icache_blocking_n),
      .bus_req_o    (icache_bus_req),
      .bus_valid_i  (icache_bus_valid),
      .bus_rdata_i  (bus_rdata_i)
   );

   // Only writer on the bus, so wdata goes straight out
   dcache u_dcache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (data_req_i),
      .flush_i      (data_flush_i),
      .rdata_o      (data_rdata_o),
      .resp_valid_o (data_resp_valid_o),
      .flush_done_o (data_flush_done_o),
      .flushing_n_o (dcache_flushing_n),
      .bus_req_o    (dcache_bus_req),
      .bus_wdata_o  (bus_wdata_o),
      .bus_valid_i  (dcache_bus_valid),
      .bus_rdata_i  (bus_rdata_i)
   );

   cache_arbiter u_cache_arbiter (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .icache_blocking_n_i(icache_blocking_n),
      .dcache_flushing_n_i(dcache_flushing_n),
      .icache_req_i       (icache_bus_req),
      .dcache_req_i       (dcache_bus_req),
      .bus_valid_i        (bus_valid_i),
      .icache_bus_valid_o (icache_bus_valid),
      .dcache_bus_valid_o (dcache_bus_valid),
      .bus_req_o          (bus_req_o)
   );

endmodule

`default_nettype wire

// ==== bench/line_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module line_memory (
   input  wire                    clk_i,
   // Request from the arbiter
   input  wire mem_pkg::bus_req_t bus_req_i,
   input  wire mem_pkg::line_t    bus_wdata_i,
   // One-cycle response
   output logic                   bus_valid_o,
   output mem_pkg::line_t         bus_rdata_o
);

   import mem_pkg::*;

   localparam int unsigned NUM_LINES = 1 << `LINE_ADDR_WIDTH;
   localparam int unsigned WORDS_PER_LINE = 1 << `WORD_SEL_BITS;

   // Whole address space, one entry per line
   line_t mem_q [NUM_LINES];

   // Delay source
   logic [31:0] lfsr_q;

   // Request being served
   logic        busy_q;
   line_addr_t  addr_q;
   logic        we_q;
   int unsigned wait_q;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   // Three fresh bits, 1 to 8 cycles
   function automatic int unsigned next_delay();
      logic [2:0] bits;
      for (int i = 0; i < 3; i++) begin
         bits[i] = lfsr_step();
      end
      return {29'd0, bits} + 32'd1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Backdoor access
   ////////////////////////////////////////////////////////////////////////////

   task automatic backdoor_read(input byte_addr_t addr, output word_t data);
      line_addr_t  line;
      int unsigned sel;
      line = addr[`BUS_ADDRESS_WIDTH-1:`BUS_DATA_WIDTH_SHIFT];
      sel = 32'(addr[2 +: `WORD_SEL_BITS]);
      data = mem_q[line][sel * `WORD_WIDTH +: `WORD_WIDTH];
   endtask

   task automatic backdoor_write(input byte_addr_t addr, input word_t data);
      line_addr_t  line;
      int unsigned sel;
      line = addr[`BUS_ADDRESS_WIDTH-1:`BUS_DATA_WIDTH_SHIFT];
      sel = 32'(addr[2 +: `WORD_SEL_BITS]);
      mem_q[line][sel * `WORD_WIDTH +: `WORD_WIDTH] = data;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus side
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      lfsr_q = 32'h2b3f2abf;
      busy_q = 1'b0;
      addr_q = '0;
      we_q = 1'b0;
      wait_q = 0;
      bus_valid_o = 1'b0;
      bus_rdata_o = '0;
      // Word at byte address a holds a ^ 5a5a0000
      for (int unsigned l = 0; l < NUM_LINES; l++) begin
         for (int unsigned w = 0; w < WORDS_PER_LINE; w++) begin
            mem_q[line_addr_t'(l)][w * `WORD_WIDTH +: `WORD_WIDTH] =
               ((l << `BUS_DATA_WIDTH_SHIFT) | (w << 2)) ^ 32'h5a5a0000;
         end
      end
      // Acts 1 ns after each rising edge, request regs are settled then
      forever begin
         @(posedge clk_i);
         #1;
         if (bus_valid_o) begin
            // Pulse lasts one cycle, cache drops valid meanwhile
            bus_valid_o = 1'b0;
            busy_q = 1'b0;
         end else if (busy_q) begin
            if (wait_q == 1) begin
               // Write data is taken in the response cycle
               if (we_q) begin
                  mem_q[addr_q] = bus_wdata_i;
               end
               bus_rdata_o = mem_q[addr_q];
               bus_valid_o = 1'b1;
            end else begin
               wait_q = wait_q - 1;
            end
         end else if (bus_req_i.valid) begin
            busy_q = 1'b1;
            addr_q = bus_req_i.addr;
            we_q = bus_req_i.we;
            wait_q = next_delay();
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

   import mem_pkg::*;

   localparam int unsigned TIMEOUT_CYCLES = 200;

   logic clk;
   logic rst;

   // Fetch port
   byte_addr_t fetch_addr;
   logic       fetch_req;
   logic       fetch_invalidate;
   word_t      fetch_data;
   logic       fetch_valid;

   // Data port
   data_req_t  data_req;
   logic       data_flush;
   word_t      data_rdata;
   logic       data_resp_valid;
   logic       data_flush_done;

   // Line bus
   bus_req_t   bus_req;
   line_t      bus_wdata;
   logic       bus_valid;
   line_t      bus_rdata;

   // Expected memory contents after each store
   word_t shadow [byte_addr_t];

   mem_subsystem u_mem_subsystem (
      .clk_i             (clk),
      .rst_i             (rst),
      .fetch_addr_i      (fetch_addr),
      .fetch_req_i       (fetch_req),
      .fetch_invalidate_i(fetch_invalidate),
      .fetch_data_o      (fetch_data),
      .fetch_valid_o     (fetch_valid),
      .data_req_i        (data_req),
      .data_flush_i      (data_flush),
      .data_rdata_o      (data_rdata),
      .data_resp_valid_o (data_resp_valid),
      .data_flush_done_o (data_flush_done),
      .bus_req_o         (bus_req),
      .bus_wdata_o       (bus_wdata),
      .bus_valid_i       (bus_valid),
      .bus_rdata_i       (bus_rdata)
   );

   line_memory u_line_memory (
      .clk_i      (clk),
      .bus_req_i  (bus_req),
      .bus_wdata_i(bus_wdata),
      .bus_valid_o(bus_valid),
      .bus_rdata_o(bus_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp) else begin
         report_failure($sformatf("error at %0t ns: %s = %h, expected %h",
                                  $time, name, got, exp));
      end
   endtask

   // Memory rule unless a store or backdoor write changed the word
   function automatic word_t expected_word(input byte_addr_t addr);
      if (shadow.exists(addr)) begin
         return shadow[addr];
      end
      return 32'(addr) ^ 32'h5a5a0000;
   endfunction

   // All drives land 1 ns after a rising edge
   task automatic fetch_word(input byte_addr_t addr, output word_t data,
                             output int unsigned cycles);
      int unsigned n;
      fetch_addr = addr;
      fetch_req = 1'b1;
      @(posedge clk);
      #1;
      fetch_req = 1'b0;
      n = 1;
      while (!fetch_valid && n < TIMEOUT_CYCLES) begin
         @(posedge clk);
         #1;
         n++;
      end
      assert (fetch_valid) else begin
         report_failure($sformatf("fetch_valid_o never came, gave up at %0t ns", $time));
      end
      data = fetch_data;
      cycles = n;
   endtask

   task automatic data_access(input byte_addr_t addr, input logic we, input word_t wdata,
                              output word_t rdata, output int unsigned cycles);
      int unsigned n;
      data_req = '{addr: addr, we: we, wdata: wdata, valid: 1'b1};
      @(posedge clk);
      #1;
      data_req.valid = 1'b0;
      n = 1;
      while (!data_resp_valid && n < TIMEOUT_CYCLES) begin
         @(posedge clk);
         #1;
         n++;
      end
      assert (data_resp_valid) else begin
         report_failure($sformatf("data_resp_valid_o never came, gave up at %0t ns", $time));
      end
      rdata = data_rdata;
      cycles = n;
   endtask

   task automatic fetch_and_check(input byte_addr_t addr, output int unsigned cycles);
      word_t got;
      fetch_word(addr, got, cycles);
      check_value("fetch_data_o", got, expected_word(addr));
   endtask

   task automatic store_word(input byte_addr_t addr, input word_t data);
      word_t       unused_rdata;
      int unsigned cycles;
      data_access(addr, 1'b1, data, unused_rdata, cycles);
      shadow[addr] = data;
   endtask

   task automatic load_and_check(input byte_addr_t addr, output int unsigned cycles);
      word_t got;
      data_access(addr, 1'b0, '0, got, cycles);
      check_value("data_rdata_o", got, expected_word(addr));
   endtask

   task automatic backdoor_check(input byte_addr_t addr);
      word_t got;
      u_line_memory.backdoor_read(addr, got);
      check_value($sformatf("memory word %h", addr), got, expected_word(addr));
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      assert (!fetch_valid && !data_resp_valid && !data_flush_done
              && !bus_req.valid) else begin
         report_failure("a valid output was still high after reset");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic fetch_miss_then_hit();
      int unsigned cycles;
      fetch_and_check(20'h10024, cycles);
      // Same line now hits
      fetch_and_check(20'h10028, cycles);
      check_value("fetch hit latency", cycles, 1);
   endtask

   task automatic store_then_load();
      int unsigned cycles;
      store_word(20'h40024, 32'h1234_0001);
      load_and_check(20'h40024, cycles);
      load_and_check(20'h40020, cycles);
      load_and_check(20'h4002c, cycles);
   endtask

   task automatic evict_dirty_line();
      int unsigned cycles;
      store_word(20'h40034, 32'h1234_0002);
      // Index 3 again with another tag
      load_and_check(20'h51034, cycles);
      backdoor_check(20'h40034);
   endtask

   task automatic flush_dirty_lines();
      int unsigned n;
      int unsigned cycles;
      store_word(20'h40040, 32'h1234_0003);
      store_word(20'h40054, 32'h1234_0004);
      store_word(20'h40068, 32'h1234_0005);
      store_word(20'h4007c, 32'h1234_0006);
      data_flush = 1'b1;
      @(posedge clk);
      #1;
      data_flush = 1'b0;
      n = 1;
      while (!data_flush_done && n < TIMEOUT_CYCLES) begin
         @(posedge clk);
         #1;
         n++;
      end
      assert (data_flush_done) else begin
         report_failure($sformatf("data_flush_done_o never came, gave up at %0t ns", $time));
      end
      // Done is a single-cycle pulse
      @(posedge clk);
      #1;
      assert (!data_flush_done) else begin
         report_failure("data_flush_done_o stayed high for more than one cycle");
      end
      foreach (shadow[a]) begin
         backdoor_check(a);
      end
      // Lines stay valid after a flush
      load_and_check(20'h40040, cycles);
      check_value("data hit latency", cycles, 1);
   endtask

   task automatic bus_contention();
      int unsigned fetch_cycles;
      int unsigned data_cycles;
      time         fetch_end;
      time         data_end;
      // Dirty victim at index 8
      store_word(20'h40084, 32'h1234_0007);
      fork
         begin
            fetch_and_check(20'h10090, fetch_cycles);
            fetch_end = $time;
         end
         begin
            load_and_check(20'h62084, data_cycles);
            data_end = $time;
         end
      join
      // Refilling icache keeps the bus
      assert (fetch_end < data_end) else begin
         report_failure("data cache finished before the instruction refill");
      end
      backdoor_check(20'h40084);
   endtask

   task automatic invalidate_and_refetch();
      int unsigned cycles;
      word_t       old_word;
      word_t       got;
      fetch_and_check(20'h100a8, cycles);
      old_word = expected_word(20'h100a8);
      u_line_memory.backdoor_write(20'h100a8, 32'h6e77_0001);
      shadow[20'h100a8] = 32'h6e77_0001;
      // Stale copy still served
      fetch_word(20'h100a8, got, cycles);
      check_value("fetch_data_o", got, old_word);
      fetch_invalidate = 1'b1;
      @(posedge clk);
      #1;
      fetch_invalidate = 1'b0;
      fetch_and_check(20'h100a8, cycles);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst = 1'b1;
      fetch_addr = '0;
      fetch_req = 1'b0;
      fetch_invalidate = 1'b0;
      data_req = '0;
      data_flush = 1'b0;
      apply_reset();
      fetch_miss_then_hit();
      store_then_load();
      evict_dirty_line();
      flush_dirty_lines();
      bus_contention();
      invalidate_and_refetch();
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_arbiter.sv
hdl/icache.sv
hdl/dcache.sv
hdl/mem_subsystem.sv
bench/line_memory.sv
bench/mem_subsystem_tb.sv

// ==== Makefile ====
TOP = mem_subsystem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
